// File: hdl/avg_pkg.sv
`default_nettype none

package avg_pkg;

  // datapath widths
  localparam int SAMPLE_W = 16;                 // adc sample
  localparam int SWEEP_W  = 8;                  // sweep counter, target up to 255
  localparam int ACC_W    = SAMPLE_W + SWEEP_W; // 255 full-scale samples cannot overflow
  localparam int ADDR_W   = 10;                 // 1024 points per sweep

  // host register bus
  localparam int REG_DW = 32; // register data width

  localparam logic [1:0] REG_CTRL   = 2'd0; // [0] avg_on, [1] restart (write only)
  localparam logic [1:0] REG_CMAX   = 2'd1; // last address of a sweep
  localparam logic [1:0] REG_SWEEPS = 2'd2; // sweep target
  localparam logic [1:0] REG_STATUS = 2'd3; // [0] ready, [15:8] n_avg

  // configuration handed from the register block to the counter
  typedef struct packed {
    logic              avg_on;    // accumulate when set
    logic [ADDR_W-1:0] count_max; // sweep wraps after this point
    logic [SWEEP_W-1:0] sweeps;   // number of sweeps to average
  } avg_cfg_t;

  // write port of the sweep memory, also seen by the checker
  typedef struct packed {
    logic              we;   // write strobe
    logic [ADDR_W-1:0] addr; // sweep point
    logic [ACC_W-1:0]  data; // new running sum
  } acc_wr_t;

endpackage

`default_nettype wire

// File: hdl/avg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module avg_regs (
  input  wire logic                         clk,
  input  wire logic                         arst_n,
  input  wire logic                         reg_we,    // write strobe, one cycle
  input  wire logic [1:0]                   reg_addr,
  input  wire logic [avg_pkg::REG_DW-1:0]   reg_wdata,
  output logic      [avg_pkg::REG_DW-1:0]   reg_rdata, // combinational readback
  output avg_pkg::avg_cfg_t                 cfg,
  output logic                              restart,   // single-cycle pulse
  input  wire logic                         ready,
  input  wire logic [avg_pkg::SWEEP_W-1:0]  n_avg
);

  // write decode
  // restart is a strobe, so it drops back to 0 unless CTRL[1] is written again
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cfg     <= '0; // averaging off, cmax 0, target 0
      restart <= 1'b0;
    end else begin
      restart <= 1'b0; // self clearing
      if (reg_we) begin
        case (reg_addr)
          avg_pkg::REG_CTRL: begin
            cfg.avg_on <= reg_wdata[0];
            restart    <= reg_wdata[1]; // pulse shows up next cycle
          end
          avg_pkg::REG_CMAX:   cfg.count_max <= reg_wdata[avg_pkg::ADDR_W-1:0];
          avg_pkg::REG_SWEEPS: cfg.sweeps    <= reg_wdata[avg_pkg::SWEEP_W-1:0];
          default: ; // status is read only
        endcase
      end
    end
  end

  // readback mux
  always_comb begin
    reg_rdata = '0;
    case (reg_addr)
      avg_pkg::REG_CTRL: begin
        reg_rdata[0] = cfg.avg_on; // restart bit always reads 0
      end
      avg_pkg::REG_CMAX: begin
        reg_rdata[avg_pkg::ADDR_W-1:0] = cfg.count_max;
      end
      avg_pkg::REG_SWEEPS: begin
        reg_rdata[avg_pkg::SWEEP_W-1:0] = cfg.sweeps;
      end
      avg_pkg::REG_STATUS: begin
        reg_rdata[0]                   = ready;
        reg_rdata[8+:avg_pkg::SWEEP_W] = n_avg; // bits 15:8
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/averager_counter.sv
`timescale 1ns/1ps
`default_nettype none

module averager_counter (
  input  wire logic                         clk,
  input  wire logic                         arst_n,
  input  wire logic                         restart,   // from CTRL[1]
  input  wire logic                         clken,     // one strobe per sample
  input  wire avg_pkg::avg_cfg_t            cfg,
  output logic      [avg_pkg::ADDR_W-1:0]   address,   // point of the current sample
  output logic                              clr_fback, // first sweep, ignore old sum
  output logic                              wen,       // write this sample
  output logic                              ready,     // target reached
  output logic      [avg_pkg::SWEEP_W-1:0]  n_avg      // completed sweeps
);

  logic                        last_pt;    // sample sits on the final point
  logic                        sweep_done; // a written sweep completes here
  logic                        last_sweep; // that sweep is the target one
  logic [avg_pkg::SWEEP_W:0]   n_avg_nxt;  // one extra bit so 255+1 never matches

  // >= also catches a count_max lowered under a running address
  assign last_pt = (address >= cfg.count_max);

  assign n_avg_nxt  = {1'b0, n_avg} + 1'b1;
  assign last_sweep = (n_avg_nxt == {1'b0, cfg.sweeps}); // target 0 never matches

  // write gating for the current strobe
  assign wen = clken && cfg.avg_on && !ready;

  // only sweeps that really went into memory are counted
  assign sweep_done = wen && last_pt;

  // first sweep of a run overwrites the memory
  assign clr_fback = (n_avg == '0);

  // sweep address, advances even when averaging is off
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      address <= '0;
    end else if (restart) begin
      address <= '0;
    end else if (clken) begin
      if (last_pt) begin
        address <= '0; // wrap
      end else begin
        address <= address + 1'b1;
      end
    end
  end

  // completed sweep count
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      n_avg <= '0;
    end else if (restart) begin
      n_avg <= '0;
    end else if (sweep_done) begin
      n_avg <= n_avg_nxt[avg_pkg::SWEEP_W-1:0];
    end
  end

  // ready latches after the wrap of the final sweep and stays until restart
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready <= 1'b0;
    end else if (restart) begin
      ready <= 1'b0;
    end else if (sweep_done && last_sweep) begin
      ready <= 1'b1; // also freezes n_avg via wen
    end
  end

endmodule

`default_nettype wire

// File: hdl/sweep_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sweep_ram (
  input  wire logic                        clk,
  input  wire avg_pkg::acc_wr_t            acc_wr,    // accumulator write port
  input  wire logic [avg_pkg::ADDR_W-1:0]  rd_addr_a, // accumulator read
  output logic      [avg_pkg::ACC_W-1:0]   rd_data_a,
  input  wire logic [avg_pkg::ADDR_W-1:0]  rd_addr_b, // host read
  output logic      [avg_pkg::ACC_W-1:0]   rd_data_b
);

  localparam int DEPTH = 2**avg_pkg::ADDR_W;

  // running sums, one word per sweep point
  logic [avg_pkg::ACC_W-1:0] mem [DEPTH];

  // write port plus read port a
  // a read of the address being written returns the old word,
  // the accumulator forwards around that case
  always_ff @(posedge clk) begin
    if (acc_wr.we) begin
      mem[acc_wr.addr] <= acc_wr.data;
    end
    rd_data_a <= mem[rd_addr_a];
  end

  // host readback, one cycle latency
  always_ff @(posedge clk) begin
    rd_data_b <= mem[rd_addr_b];
  end

endmodule

`default_nettype wire

// File: hdl/avg_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module avg_accumulator (
  input  wire logic                         clk,
  input  wire logic                         arst_n,
  input  wire logic                         restart,
  input  wire logic                         clken,     // sample strobe
  input  wire logic [avg_pkg::SAMPLE_W-1:0] sample,
  input  wire logic [avg_pkg::ADDR_W-1:0]   address,
  input  wire logic                         wen,
  input  wire logic                         clr_fback,
  output logic      [avg_pkg::ADDR_W-1:0]   rd_addr_a, // read of the old sum
  input  wire logic [avg_pkg::ACC_W-1:0]    rd_data_a,
  output avg_pkg::acc_wr_t                  acc_wr
);

  localparam int EXT_W = avg_pkg::ACC_W - avg_pkg::SAMPLE_W; // zero extension

  // stage 0, captured in the strobe cycle
  logic                         s0_valid;
  logic [avg_pkg::ADDR_W-1:0]   s0_addr;
  logic [avg_pkg::SAMPLE_W-1:0] s0_sample;
  logic                         s0_clr;

  // forwarding of the word written while stage 0 was reading
  logic                         fwd_sel;
  logic [avg_pkg::ACC_W-1:0]    fwd_data;
  logic                         fwd_hit;

  logic [avg_pkg::ACC_W-1:0]    old_sum; // feedback term

  // memory read issued together with the strobe
  assign rd_addr_a = address;

  // a write in flight to the same point makes the memory read stale
  assign fwd_hit = acc_wr.we && (acc_wr.addr == address);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s0_valid <= 1'b0;
      fwd_sel  <= 1'b0;
    end else if (restart) begin
      s0_valid <= 1'b0; // drop anything in flight
      fwd_sel  <= 1'b0;
    end else begin
      s0_valid <= clken && wen;
      fwd_sel  <= fwd_hit;
    end
  end

  // payload, qualified by s0_valid
  always_ff @(posedge clk) begin
    s0_addr   <= address;
    s0_sample <= sample;
    s0_clr    <= clr_fback;
    fwd_data  <= acc_wr.data;
  end

  // stage 1, add and write back
  always_comb begin
    if (s0_clr) begin
      old_sum = '0; // first sweep overwrites
    end else if (fwd_sel) begin
      old_sum = fwd_data; // back-to-back same point
    end else begin
      old_sum = rd_data_a;
    end
  end

  assign acc_wr.we   = s0_valid;
  assign acc_wr.addr = s0_addr;
  assign acc_wr.data = old_sum + {{EXT_W{1'b0}}, s0_sample};

endmodule

`default_nettype wire

// File: hdl/signal_averager.sv
`timescale 1ns/1ps
`default_nettype none

module signal_averager (
  input  wire logic                         clk,
  input  wire logic                         arst_n,
  // host register bus
  input  wire logic                         reg_we,
  input  wire logic [1:0]                   reg_addr,
  input  wire logic [avg_pkg::REG_DW-1:0]   reg_wdata,
  output logic      [avg_pkg::REG_DW-1:0]   reg_rdata,
  // adc side
  input  wire logic                         clken,
  input  wire logic [avg_pkg::SAMPLE_W-1:0] sample,
  // host readback of the sums
  input  wire logic [avg_pkg::ADDR_W-1:0]   rd_addr,
  output logic      [avg_pkg::ACC_W-1:0]    rd_data,
  output logic                              ready
);

  avg_pkg::avg_cfg_t           cfg;
  logic                        restart;
  logic [avg_pkg::SWEEP_W-1:0] n_avg;
  logic [avg_pkg::ADDR_W-1:0]  address;
  logic                        clr_fback;
  logic                        wen;
  logic [avg_pkg::ADDR_W-1:0]  rd_addr_a;
  logic [avg_pkg::ACC_W-1:0]   rd_data_a;
  avg_pkg::acc_wr_t            acc_wr;

  avg_regs u_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .cfg       (cfg),
    .restart   (restart),
    .ready     (ready),
    .n_avg     (n_avg)
  );

  averager_counter u_counter (
    .clk       (clk),
    .arst_n    (arst_n),
    .restart   (restart),
    .clken     (clken),
    .cfg       (cfg),
    .address   (address),
    .clr_fback (clr_fback),
    .wen       (wen),
    .ready     (ready),
    .n_avg     (n_avg)
  );

  avg_accumulator u_acc (
    .clk       (clk),
    .arst_n    (arst_n),
    .restart   (restart),
    .clken     (clken),
    .sample    (sample),
    .address   (address),
    .wen       (wen),
    .clr_fback (clr_fback),
    .rd_addr_a (rd_addr_a),
    .rd_data_a (rd_data_a),
    .acc_wr    (acc_wr)
  );

  sweep_ram u_ram (
    .clk       (clk),
    .acc_wr    (acc_wr),
    .rd_addr_a (rd_addr_a),
    .rd_data_a (rd_data_a),
    .rd_addr_b (rd_addr),  // host port
    .rd_data_b (rd_data)
  );

endmodule

`default_nettype wire

// File: bench/signal_averager_checker.sv
`timescale 1ns/1ps
`default_nettype none

module signal_averager_checker (
  input wire logic                       clk,
  input wire logic                       arst_n,
  input wire logic                       restart,
  input wire logic                       wen,     // counter write gate
  input wire logic                       ready,
  input wire avg_pkg::avg_cfg_t          cfg,
  input wire logic [avg_pkg::ADDR_W-1:0] address, // counter output
  input wire avg_pkg::acc_wr_t           acc_wr   // accumulator write port
);

  int fail_cnt = 0; // failed assertions so far

  // sweep address stays inside the programmed sweep
  a_addr_range: assert property (@(posedge clk) disable iff (!arst_n)
    address <= cfg.count_max)
    else begin
      $error("address %h beyond count_max %h", address, cfg.count_max);
      fail_cnt++;
    end

  // no memory write issued once the target is reached
  a_no_wr_ready: assert property (@(posedge clk) disable iff (!arst_n)
    ready |=> !acc_wr.we)
    else begin
      $error("acc_wr.we high after ready");
      fail_cnt++;
    end

  // write port follows the gate by one cycle unless restart dropped the sample
  a_we_delay: assert property (@(posedge clk) disable iff (!arst_n)
    !restart |=> (acc_wr.we == $past(wen)))
    else begin
      $error("acc_wr.we %h does not follow wen", acc_wr.we);
      fail_cnt++;
    end

  a_restart_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    restart |=> !restart)
    else begin
      $error("restart held longer than one cycle");
      fail_cnt++;
    end

endmodule

// counter and pipeline nets as seen in the top level
bind signal_averager signal_averager_checker u_chk (
  .clk     (clk),
  .arst_n  (arst_n),
  .restart (restart),
  .wen     (wen),
  .ready   (ready),
  .cfg     (cfg),
  .address (address),
  .acc_wr  (acc_wr)
);

`default_nettype wire

// File: bench/signal_averager_tb.sv
`timescale 1ns/1ps
`default_nettype none

module signal_averager_tb;

  localparam int CLK_NS        = 4;
  localparam int TOTAL_SAMPLES = 148; // 5x16 + 2x16 + 16 + 20 strobes over all tests
  localparam int MARGIN_CYCLES = 400; // register access, readback scans, drains
  localparam int WATCHDOG_NS   = (TOTAL_SAMPLES * 4 + MARGIN_CYCLES) * CLK_NS;
  localparam int NPTS          = 16;  // sweep points compared by the scans

  logic                         clk;
  logic                         arst_n;
  logic                         reg_we;
  logic [1:0]                   reg_addr;
  logic [avg_pkg::REG_DW-1:0]   reg_wdata;
  logic [avg_pkg::REG_DW-1:0]   reg_rdata;
  logic                         clken;
  logic [avg_pkg::SAMPLE_W-1:0] sample;
  logic [avg_pkg::ADDR_W-1:0]   rd_addr;
  logic [avg_pkg::ACC_W-1:0]    rd_data;
  logic                         ready;

  integer seed;                               // $random state
  int     value_errs;                         // wrong values seen
  int     other_errs;                         // timeouts and the like
  logic   scan_req;                           // main -> compare process
  logic [avg_pkg::SAMPLE_W-1:0] smp [32][NPTS]; // samples by sweep and point
  logic [avg_pkg::ACC_W-1:0]    exp_mem [NPTS]; // expected memory image

  signal_averager uut (
    .clk       (clk),
    .arst_n    (arst_n),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata),
    .clken     (clken),
    .sample    (sample),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .ready     (ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  // expected running sum at one point over the sweeps that went into memory
  function automatic logic [avg_pkg::ACC_W-1:0] ref_sum(input int addr, input int n_sw);
    logic [avg_pkg::ACC_W-1:0] acc;
    int s;
    acc = '0;
    for (s = 0; s < n_sw; s++) begin
      acc = acc + avg_pkg::ACC_W'(smp[s][addr]); // zero extended sample
    end
    return acc;
  endfunction

  task automatic write_reg(input logic [1:0] a, input logic [avg_pkg::REG_DW-1:0] d);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = a;
    reg_wdata = d;
    @(negedge clk);
    reg_we    = 1'b0; // one-cycle strobe
  endtask

  task automatic read_reg(input logic [1:0] a, output logic [avg_pkg::REG_DW-1:0] d);
    @(negedge clk);
    reg_addr = a;
    #1;           // readback is combinational, settled well before the rising edge
    d = reg_rdata;
  endtask

  // n_sw sweeps of cmax+1 points each, optional random idle cycles between strobes
  task automatic run_sweeps(input int n_sw, input int cmax, input bit gaps);
    int     s;
    int     a;
    int     g;
    integer rnd;
    for (s = 0; s < n_sw; s++) begin
      for (a = 0; a <= cmax; a++) begin
        @(negedge clk);
        rnd       = $random(seed);
        sample    = rnd[avg_pkg::SAMPLE_W-1:0];
        smp[s][a] = rnd[avg_pkg::SAMPLE_W-1:0];
        clken     = 1'b1;
        if (gaps) begin
          g = {$random(seed)} % 4; // 0 keeps the strobes back to back
          repeat (g) begin
            @(negedge clk);
            clken = 1'b0;
          end
        end
      end
    end
    @(negedge clk);
    clken = 1'b0;
  endtask

  task automatic wait_ready(input int limit);
    int n;
    n = 0;
    while (ready !== 1'b1 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (ready !== 1'b1) begin
      other_errs++;
      $display("ready did not rise within %0d cycles after the last sample", limit);
    end
  endtask

  task automatic drain_pipeline();
    repeat (3) @(negedge clk); // last write lands two edges after its strobe
  endtask

  // hand the compare process a full scan and wait until it is done
  task automatic scan_memory();
    scan_req = 1'b1;
    wait (scan_req == 1'b0);
  endtask

  task automatic check_status(input logic exp_ready, input logic [avg_pkg::SWEEP_W-1:0] exp_n);
    logic [avg_pkg::REG_DW-1:0] st;
    read_reg(avg_pkg::REG_STATUS, st);
    if (st[0] !== exp_ready) begin
      value_errs++;
      $display("ERR status.ready: expected %h, got %h", exp_ready, st[0]);
    end
    if (st[8+:avg_pkg::SWEEP_W] !== exp_n) begin
      value_errs++;
      $display("ERR n_avg: expected %h, got %h", exp_n, st[8+:avg_pkg::SWEEP_W]);
    end
    if (ready !== exp_ready) begin
      value_errs++;
      $display("ERR ready: expected %h, got %h", exp_ready, ready);
    end
  endtask

  // compare process, host port B against the expected image
  initial begin
    int a;
    forever begin
      wait (scan_req == 1'b1);
      for (a = 0; a < NPTS; a++) begin
        @(negedge clk);
        rd_addr = avg_pkg::ADDR_W'(a);
        @(negedge clk); // one cycle read latency
        if (rd_data !== exp_mem[a]) begin
          value_errs++;
          $display("ERR rd_data @%h: expected %h, got %h", a, exp_mem[a], rd_data);
        end
      end
      scan_req = 1'b0;
    end
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int a;
    int chk_errs;
    seed       = 76629;
    value_errs = 0;
    other_errs = 0;
    scan_req   = 1'b0;
    arst_n     = 1'b0;
    reg_we     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    clken      = 1'b0;
    sample     = '0;
    rd_addr    = '0;
    repeat (2) @(negedge clk);
    arst_n = 1'b1;

    // accumulation, 16 points x 4 sweeps, strobe every cycle
    write_reg(avg_pkg::REG_CMAX, 32'd15);
    write_reg(avg_pkg::REG_SWEEPS, 32'd4);
    write_reg(avg_pkg::REG_CTRL, 32'h3); // avg_on plus restart
    run_sweeps(4, 15, 1'b0);
    wait_ready(8);
    drain_pipeline();
    for (a = 0; a < NPTS; a++) exp_mem[a] = ref_sum(a, 4);
    scan_memory();
    check_status(1'b1, 8'd4);

    // stop at target, a fifth sweep must leave memory alone
    run_sweeps(1, 15, 1'b0);
    drain_pipeline();
    scan_memory();
    check_status(1'b1, 8'd4);

    // restart, two sweeps overwrite the old sums
    write_reg(avg_pkg::REG_SWEEPS, 32'd2);
    write_reg(avg_pkg::REG_CTRL, 32'h3);
    run_sweeps(2, 15, 1'b0);
    wait_ready(8);
    drain_pipeline();
    for (a = 0; a < NPTS; a++) exp_mem[a] = ref_sum(a, 2);
    scan_memory();
    check_status(1'b1, 8'd2);

    // averaging off, restart clears ready so only avg_on gates the writes
    write_reg(avg_pkg::REG_CTRL, 32'h2);
    run_sweeps(1, 15, 1'b0);
    drain_pipeline();
    scan_memory();
    check_status(1'b0, 8'd0);

    // single point sweeps with random gaps, hits the forwarding path
    write_reg(avg_pkg::REG_CMAX, 32'd0);
    write_reg(avg_pkg::REG_SWEEPS, 32'd20);
    write_reg(avg_pkg::REG_CTRL, 32'h3);
    run_sweeps(20, 0, 1'b1);
    wait_ready(8);
    drain_pipeline();
    exp_mem[0] = ref_sum(0, 20); // points 1..15 keep the earlier sums
    scan_memory();
    check_status(1'b1, 8'd20);

    chk_errs = uut.u_chk.fail_cnt; // assertion failures from the bound checker
    $display("done: %0d value errors, %0d other errors, %0d assertion failures",
             value_errs, other_errs, chk_errs);
    if (value_errs == 0 && other_errs == 0 && chk_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: signal_averager.f
hdl/avg_pkg.sv
hdl/avg_regs.sv
hdl/averager_counter.sv
hdl/sweep_ram.sv
hdl/avg_accumulator.sv
hdl/signal_averager.sv
bench/signal_averager_checker.sv
bench/signal_averager_tb.sv

// File: Makefile
TOP := signal_averager_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal --top-module $(TOP) -f signal_averager.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-Mdir obj_dir -f signal_averager.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 ; cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log || (echo "no verdict in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
